//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = tb_shader_core
FLIST = flist.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- flist.f
+incdir+src
+incdir+verif
src/shader_core_pkg.sv
src/core_sequencer.sv
src/inst_decoder.sv
src/register_file.sv
src/execute_unit.sv
src/writeback_unit.sv
src/shader_core.sv
verif/tb_shader_core.sv

//--- src/core_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module core_sequencer (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     run,
    input  shader_core_pkg::opcode_e opcode,
    input  logic                     halt_request,
    input  shader_core_pkg::word_t   pc,
    input  shader_core_pkg::word_t   alu_result,
    input  shader_core_pkg::word_t   rs2_value,
    output shader_core_pkg::addr_t   inst_ram_address,
    output shader_core_pkg::addr_t   data_ram_address,
    output shader_core_pkg::word_t   data_ram_write_data,
    output logic                     data_ram_write,
    output logic                     load_inst,
    output logic                     retire,
    output logic                     halted
);

    shader_core_pkg::core_state_e state;

    // the stages qualify these phase strobes with run
    assign load_inst = (state == shader_core_pkg::state_decode);
    assign retire = (state == shader_core_pkg::state_retire);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= shader_core_pkg::state_init;
            data_ram_write <= 1'b0;
            halted <= 1'b0;
        end else if (run) begin
            case (state)
                shader_core_pkg::state_init: state <= shader_core_pkg::state_fetch;
                shader_core_pkg::state_fetch: state <= shader_core_pkg::state_fetch2;
                // read data for the fetched address arrives in decode
                shader_core_pkg::state_fetch2: state <= shader_core_pkg::state_decode;
                shader_core_pkg::state_decode: state <= shader_core_pkg::state_execute;
                shader_core_pkg::state_execute: begin
                    if (halt_request) begin
                        halted <= 1'b1;
                        state <= shader_core_pkg::state_halted;
                    end else if (opcode == shader_core_pkg::op_load) begin
                        state <= shader_core_pkg::state_load;
                    end else if (opcode == shader_core_pkg::op_store) begin
                        state <= shader_core_pkg::state_store;
                    end else begin
                        state <= shader_core_pkg::state_retire;
                    end
                end
                shader_core_pkg::state_load: state <= shader_core_pkg::state_load2;
                shader_core_pkg::state_load2: state <= shader_core_pkg::state_retire;
                shader_core_pkg::state_store: begin
                    // write strobe is high for the whole retire cycle
                    data_ram_write <= 1'b1;
                    state <= shader_core_pkg::state_retire;
                end
                shader_core_pkg::state_retire: begin
                    data_ram_write <= 1'b0;
                    state <= shader_core_pkg::state_fetch;
                end
                shader_core_pkg::state_halted: state <= shader_core_pkg::state_halted;
                default: state <= shader_core_pkg::state_init;
            endcase
        end
    end

    // RAM address and store data registers
    always_ff @(posedge clock) begin
        if (run) begin
            if (state == shader_core_pkg::state_fetch) begin
                inst_ram_address <= shader_core_pkg::addr_t'(pc);
            end
            if (state == shader_core_pkg::state_load || state == shader_core_pkg::state_store) begin
                data_ram_address <= shader_core_pkg::addr_t'(alu_result);
            end
            if (state == shader_core_pkg::state_store) begin
                data_ram_write_data <= rs2_value;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  shader_core_pkg::opcode_e opcode,
    input  logic [2:0]               funct3,
    input  logic                     alt_funct,
    input  shader_core_pkg::word_t   imm,
    input  shader_core_pkg::word_t   pc,
    input  shader_core_pkg::word_t   rs1_value,
    input  shader_core_pkg::word_t   rs2_value,
    output shader_core_pkg::word_t   alu_result,
    output logic                     branch_taken
);

    logic is_shift;
    logic branch_condition;
    shader_core_pkg::word_t operand1;
    shader_core_pkg::word_t operand2;
    shader_core_pkg::alu_op_e funct_op;
    shader_core_pkg::alu_op_e alu_op;

    assign is_shift = (funct3 == 3'd1) || (funct3 == 3'd5);

    // funct3 map shared by both ALU formats, sub exists only in register form
    always_comb begin
        case (funct3)
            3'd0: begin
                funct_op = (alt_funct && opcode == shader_core_pkg::op_alu_reg) ?
                           shader_core_pkg::alu_sub : shader_core_pkg::alu_add;
            end
            3'd1: funct_op = shader_core_pkg::alu_sll;
            3'd2: funct_op = shader_core_pkg::alu_slt;
            3'd3: funct_op = shader_core_pkg::alu_sltu;
            3'd4: funct_op = shader_core_pkg::alu_xor;
            3'd5: funct_op = alt_funct ? shader_core_pkg::alu_sra : shader_core_pkg::alu_srl;
            3'd6: funct_op = shader_core_pkg::alu_or;
            default: funct_op = shader_core_pkg::alu_and;
        endcase
    end

    // operand and operator selection per opcode
    always_comb begin
        operand1 = rs1_value;
        operand2 = imm;
        alu_op = shader_core_pkg::alu_add;
        case (opcode)
            shader_core_pkg::op_alu_imm: begin
                operand2 = is_shift ? shader_core_pkg::word_t'(imm[4:0]) : imm;
                alu_op = funct_op;
            end
            shader_core_pkg::op_alu_reg: begin
                operand2 = is_shift ? shader_core_pkg::word_t'(rs2_value[4:0]) : rs2_value;
                alu_op = funct_op;
            end
            shader_core_pkg::op_jalr, shader_core_pkg::op_load, shader_core_pkg::op_store: ;
            shader_core_pkg::op_lui: begin
                operand1 = imm;
                operand2 = '0;
            end
            shader_core_pkg::op_jal, shader_core_pkg::op_branch: operand1 = pc;
            default: begin
                operand1 = '0;
                operand2 = '0;
                alu_op = shader_core_pkg::alu_none;
            end
        endcase
    end

    always_comb begin
        case (alu_op)
            shader_core_pkg::alu_add: alu_result = operand1 + operand2;
            shader_core_pkg::alu_sub: alu_result = operand1 - operand2;
            shader_core_pkg::alu_sll: alu_result = operand1 << operand2[4:0];
            shader_core_pkg::alu_srl: alu_result = operand1 >> operand2[4:0];
            shader_core_pkg::alu_sra: begin
                alu_result = shader_core_pkg::word_t'($signed(operand1) >>> operand2[4:0]);
            end
            shader_core_pkg::alu_xor: alu_result = operand1 ^ operand2;
            shader_core_pkg::alu_and: alu_result = operand1 & operand2;
            shader_core_pkg::alu_or: alu_result = operand1 | operand2;
            shader_core_pkg::alu_slt: begin
                alu_result = shader_core_pkg::word_t'($signed(operand1) < $signed(operand2));
            end
            shader_core_pkg::alu_sltu: alu_result = shader_core_pkg::word_t'(operand1 < operand2);
            default: alu_result = '0;
        endcase
    end

    // branch target comes from the ALU, the condition compares rs1 with rs2
    always_comb begin
        case (funct3)
            3'd0: branch_condition = (rs1_value == rs2_value);
            3'd1: branch_condition = (rs1_value != rs2_value);
            3'd4: branch_condition = ($signed(rs1_value) < $signed(rs2_value));
            3'd5: branch_condition = ($signed(rs1_value) >= $signed(rs2_value));
            3'd6: branch_condition = (rs1_value < rs2_value);
            3'd7: branch_condition = (rs1_value >= rs2_value);
            default: branch_condition = 1'b0;
        endcase
    end

    assign branch_taken = (opcode == shader_core_pkg::op_branch) && branch_condition;

endmodule

`default_nettype wire

//--- src/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "shader_core_macros.svh"

module inst_decoder (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       run,
    input  logic                       load_inst,
    input  shader_core_pkg::word_t     inst_ram_read_data,
    output shader_core_pkg::opcode_e   opcode,
    output shader_core_pkg::reg_addr_t rs1,
    output shader_core_pkg::reg_addr_t rs2,
    output shader_core_pkg::reg_addr_t rd,
    output logic [2:0]                 funct3,
    output logic                       alt_funct,
    output logic                       halt_request,
    output shader_core_pkg::word_t     imm
);

    shader_core_pkg::word_t inst;

    // all-zero instruction decodes as an unknown opcode
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            inst <= '0;
        end else if (run && load_inst) begin
            inst <= inst_ram_read_data;
        end
    end

    assign opcode = shader_core_pkg::opcode_e'(inst[6:0]);
    assign rd = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    // selects sub and sra
    assign alt_funct = inst[30];

    // one sign-extended immediate per format
    always_comb begin
        case (opcode)
            shader_core_pkg::op_jalr,
            shader_core_pkg::op_load,
            shader_core_pkg::op_alu_imm,
            shader_core_pkg::op_system: imm = {{20{inst[31]}}, inst[31:20]};
            shader_core_pkg::op_store: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            shader_core_pkg::op_branch: begin
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            shader_core_pkg::op_jal: begin
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            shader_core_pkg::op_lui: imm = {inst[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

    assign halt_request = (opcode == shader_core_pkg::op_system) &&
                          (imm == shader_core_pkg::word_t'(`SC_HALT_IMM));

endmodule

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "shader_core_macros.svh"

module register_file (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       rd_write,
    input  shader_core_pkg::reg_addr_t rd_address,
    input  shader_core_pkg::reg_addr_t rs1,
    input  shader_core_pkg::reg_addr_t rs2,
    input  shader_core_pkg::word_t     rd_value,
    output shader_core_pkg::word_t     rs1_value,
    output shader_core_pkg::word_t     rs2_value
);

    localparam int reg_count = 2 ** `SC_REG_ADDR_WIDTH;

    // x0 has no storage
    shader_core_pkg::word_t regs [1:reg_count-1];

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            for (int i = 1; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_write && rd_address != '0) begin
            regs[rd_address] <= rd_value;
        end
    end

    assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- src/shader_core.sv
`timescale 1ns/1ps
`default_nettype none

module shader_core (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   run,
    input  shader_core_pkg::word_t inst_ram_read_data,
    input  shader_core_pkg::word_t data_ram_read_data,
    output shader_core_pkg::addr_t inst_ram_address,
    output shader_core_pkg::addr_t data_ram_address,
    output shader_core_pkg::word_t data_ram_write_data,
    output logic                   data_ram_write,
    output logic                   halted
);

    // decoded instruction fields
    shader_core_pkg::opcode_e opcode;
    shader_core_pkg::reg_addr_t rs1;
    shader_core_pkg::reg_addr_t rs2;
    shader_core_pkg::reg_addr_t rd;
    logic [2:0] funct3;
    logic alt_funct;
    logic halt_request;
    shader_core_pkg::word_t imm;

    // operands and results
    shader_core_pkg::word_t rs1_value;
    shader_core_pkg::word_t rs2_value;
    shader_core_pkg::word_t alu_result;
    logic branch_taken;

    // sequencing and register write-back
    logic load_inst;
    logic retire;
    shader_core_pkg::word_t pc;
    shader_core_pkg::word_t rd_value;
    shader_core_pkg::reg_addr_t rd_address;
    logic rd_write;

    // every port name matches its net in this scope
    core_sequencer i_core_sequencer (.*);

    inst_decoder i_inst_decoder (.*);

    register_file i_register_file (.*);

    execute_unit i_execute_unit (.*);

    writeback_unit i_writeback_unit (.*);

endmodule

`default_nettype wire

//--- src/shader_core_macros.svh
`ifndef SHADER_CORE_MACROS_SVH
`define SHADER_CORE_MACROS_SVH

// data path and RAM widths
`define SC_WORD_WIDTH 32
`define SC_ADDRESS_WIDTH 16
`define SC_REG_ADDR_WIDTH 5

// pc step per instruction, in bytes
`define SC_INST_BYTES 4

// system immediate that stops the core
`define SC_HALT_IMM 1

`endif

//--- src/shader_core_pkg.sv
`default_nettype none

`include "shader_core_macros.svh"

package shader_core_pkg;

    typedef logic [`SC_WORD_WIDTH-1:0] word_t;
    typedef logic [`SC_ADDRESS_WIDTH-1:0] addr_t;
    typedef logic [`SC_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // RV32I major opcodes handled by the core, anything else retires as a no-op
    typedef enum logic [6:0] {
        op_load    = 7'b0000011,
        op_alu_imm = 7'b0010011,
        op_store   = 7'b0100011,
        op_alu_reg = 7'b0110011,
        op_lui     = 7'b0110111,
        op_branch  = 7'b1100011,
        op_jalr    = 7'b1100111,
        op_jal     = 7'b1101111,
        op_system  = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd1,
        alu_sub  = 4'd2,
        alu_sll  = 4'd3,
        alu_srl  = 4'd4,
        alu_sra  = 4'd5,
        alu_xor  = 4'd6,
        alu_and  = 4'd7,
        alu_or   = 4'd8,
        alu_slt  = 4'd9,
        alu_sltu = 4'd10,
        alu_none = 4'd11
    } alu_op_e;

    // encoding 5 is left unused
    typedef enum logic [3:0] {
        state_init    = 4'd0,
        state_fetch   = 4'd1,
        state_fetch2  = 4'd2,
        state_decode  = 4'd3,
        state_execute = 4'd4,
        state_retire  = 4'd6,
        state_load    = 4'd7,
        state_load2   = 4'd8,
        state_store   = 4'd9,
        state_halted  = 4'd10
    } core_state_e;

endpackage

`default_nettype wire

//--- src/writeback_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "shader_core_macros.svh"

module writeback_unit (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       run,
    input  logic                       retire,
    input  logic                       branch_taken,
    input  shader_core_pkg::opcode_e   opcode,
    input  shader_core_pkg::reg_addr_t rd,
    input  shader_core_pkg::word_t     alu_result,
    input  shader_core_pkg::word_t     data_ram_read_data,
    output shader_core_pkg::word_t     pc,
    output shader_core_pkg::word_t     rd_value,
    output shader_core_pkg::reg_addr_t rd_address,
    output logic                       rd_write
);

    localparam shader_core_pkg::word_t inst_step = `SC_INST_BYTES;

    logic is_jump;
    logic writes_rd;

    assign is_jump = (opcode == shader_core_pkg::op_jal) || (opcode == shader_core_pkg::op_jalr);
    assign writes_rd = is_jump || opcode inside {
        shader_core_pkg::op_alu_imm,
        shader_core_pkg::op_alu_reg,
        shader_core_pkg::op_lui,
        shader_core_pkg::op_load
    };

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            pc <= '0;
            rd_write <= 1'b0;
        end else if (run) begin
            // single pulse, the register file commits it on the next edge
            rd_write <= retire && writes_rd && (rd != '0);
            if (retire) begin
                if (is_jump) begin
                    pc <= alu_result & ~shader_core_pkg::word_t'(1);
                end else if (branch_taken) begin
                    pc <= alu_result;
                end else begin
                    pc <= pc + inst_step;
                end
            end
        end
    end

    // write-back value, taken while pc still holds this instruction
    always_ff @(posedge clock) begin
        if (run && retire) begin
            rd_address <= rd;
            if (is_jump) begin
                rd_value <= pc + inst_step;
            end else if (opcode == shader_core_pkg::op_load) begin
                rd_value <= data_ram_read_data;
            end else begin
                rd_value <= alu_result;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_reference_model.svh
`ifndef TB_REFERENCE_MODEL_SVH
`define TB_REFERENCE_MODEL_SVH

// RV32I integer ALU semantics
function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
        3'd0: begin
            if (alt) r = a - b;
            else r = a + b;
        end
        3'd1: r = a << b[4:0];
        3'd2: r = {31'b0, $signed(a) < $signed(b)};
        3'd3: r = {31'b0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
            if (alt) r = $signed(a) >>> b[4:0];
            else r = a >> b[4:0];
        end
        3'd6: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

// interprets prog from address 0, updates exp_mem and returns the number
// of executed instructions including the halt
function automatic int run_reference();
    logic [31:0] x [32];
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] addr;
    logic [31:0] result;
    logic [31:0] next_pc;
    logic write_rd;
    logic take;
    int executed;
    foreach (x[i]) x[i] = '0;
    pc = '0;
    executed = 0;
    while (executed < 100000) begin
        inst = prog[pc[11:2]];
        executed++;
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        a = x[inst[19:15]];
        b = x[inst[24:20]];
        next_pc = pc + 32'd4;
        write_rd = 1'b0;
        result = '0;
        case (inst[6:0])
            7'h13: begin
                write_rd = 1'b1;
                result = alu_model(inst[14:12], inst[14:12] == 3'd5 && inst[30], a, imm_i);
            end
            7'h33: begin
                write_rd = 1'b1;
                result = alu_model(inst[14:12], inst[30], a, b);
            end
            7'h37: begin
                write_rd = 1'b1;
                result = {inst[31:12], 12'b0};
            end
            7'h6f: begin
                write_rd = 1'b1;
                result = pc + 32'd4;
                next_pc = pc + imm_j;
            end
            7'h67: begin
                write_rd = 1'b1;
                result = pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                case (inst[14:12])
                    3'd0: take = (a == b);
                    3'd1: take = (a != b);
                    3'd4: take = ($signed(a) < $signed(b));
                    3'd5: take = ($signed(a) >= $signed(b));
                    3'd6: take = (a < b);
                    3'd7: take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) next_pc = pc + imm_b;
            end
            7'h03: begin
                write_rd = 1'b1;
                addr = a + imm_i;
                result = exp_mem[addr[11:2]];
            end
            7'h23: begin
                addr = a + imm_s;
                exp_mem[addr[11:2]] = b;
            end
            7'h73: begin
                if (imm_i == 32'd1) return executed;
            end
            default: ;
        endcase
        if (write_rd && inst[11:7] != 5'd0) x[inst[11:7]] = result;
        pc = next_pc;
    end
    return executed;
endfunction

`endif

//--- verif/tb_shader_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_shader_core;

    localparam int mem_words = 1024;

    logic clock = 1'b0;
    logic reset_n;
    logic run;
    logic stall_enable;
    shader_core_pkg::word_t inst_ram_read_data;
    shader_core_pkg::word_t data_ram_read_data;
    shader_core_pkg::addr_t inst_ram_address;
    shader_core_pkg::addr_t data_ram_address;
    shader_core_pkg::word_t data_ram_write_data;
    logic data_ram_write;
    logic halted;

    logic [31:0] prog [mem_words];
    logic [31:0] dmem [mem_words];
    logic [31:0] exp_mem [mem_words];
    int prog_len;
    int errors;
    // funct3 for each ALU kind in the order add sub sll slt sltu xor srl sra or and
    int f3_of [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};

    `include "tb_reference_model.svh"

    shader_core i_shader_core (.*);

    initial begin
        forever #5 clock = ~clock;
    end

    // synchronous RAM models indexed by word
    always @(posedge clock) begin
        inst_ram_read_data <= prog[inst_ram_address[11:2]];
        data_ram_read_data <= dmem[data_ram_address[11:2]];
        if (data_ram_write) dmem[data_ram_address[11:2]] <= data_ram_write_data;
    end

    // run drops low for random spans while stalling is enabled
    always @(negedge clock) begin
        run = stall_enable ? ($urandom % 3 != 0) : 1'b1;
    end

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] r_type(input logic alt, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'd2, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] fill_pattern(input int i);
        return (i * 32'h9e3779b1) ^ 32'h5bd1e995;
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic clear_program();
        foreach (prog[i]) prog[i] = '0;
        prog_len = 0;
    endtask

    task automatic init_regs(input int regs);
        for (int r = 1; r < regs; r++) begin
            emit({20'($urandom), 5'(r), 7'h37});
            emit(i_type(12'($urandom), 5'(r), 3'd0, 5'(r), 7'h13));
        end
    endtask

    task automatic add_alu_op(input int regs, input int kind);
        logic [2:0] f3;
        logic alt;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        f3 = 3'(f3_of[kind]);
        alt = (kind == 1) || (kind == 7);
        rd = 5'($urandom % regs);
        rs1 = 5'($urandom % regs);
        rs2 = 5'($urandom % regs);
        if (kind == 1 || $urandom % 2 == 0) begin
            emit(r_type(alt, rs2, rs1, f3, rd));
        end else if (f3 == 3'd1 || f3 == 3'd5) begin
            emit(i_type({1'b0, alt, 5'b0, 5'($urandom)}, rs1, f3, rd, 7'h13));
        end else begin
            emit(i_type(12'($urandom), rs1, f3, rd, 7'h13));
        end
    endtask

    task automatic add_dump_and_halt();
        for (int r = 0; r < 32; r++) emit(s_type(12'('h600 + 4 * r), 5'(r)));
        emit(i_type(12'd1, 5'd0, 3'd0, 5'd0, 7'h73));
    endtask

    task automatic build_control_program();
        logic [4:0] ra;
        logic [4:0] rb;
        int conds [6] = '{0, 1, 4, 5, 6, 7};
        int target;
        clear_program();
        init_regs(16);
        foreach (conds[c]) begin
            ra = 5'(1 + $urandom % 15);
            // rb is always a different register than ra
            rb = 5'(1 + (ra + $urandom % 14) % 15);
            // equal, forward and swapped operands give both outcomes
            emit(b_type(13'd8, ra, ra, 3'(conds[c])));
            emit(i_type(12'd1, 5'd16, 3'd0, 5'd16, 7'h13));
            emit(b_type(13'd8, rb, ra, 3'(conds[c])));
            emit(i_type(12'd2, 5'd16, 3'd0, 5'd16, 7'h13));
            emit(b_type(13'd8, ra, rb, 3'(conds[c])));
            emit(i_type(12'd4, 5'd16, 3'd0, 5'd16, 7'h13));
        end
        // backward loop counting down in x17
        emit(i_type(12'(3 + $urandom % 4), 5'd0, 3'd0, 5'd17, 7'h13));
        emit(i_type(12'd1, 5'd18, 3'd0, 5'd18, 7'h13));
        emit(i_type(12'hfff, 5'd17, 3'd0, 5'd17, 7'h13));
        emit(b_type(13'h1ff8, 5'd0, 5'd17, 3'd1));
        emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd19, 7'h6f});
        emit(i_type(12'd100, 5'd16, 3'd0, 5'd16, 7'h13));
        target = prog_len * 4 + 8;
        emit(i_type(12'(target + $urandom % 2), 5'd0, 3'd0, 5'd20, 7'h67));
        emit(i_type(12'd200, 5'd16, 3'd0, 5'd16, 7'h13));
        add_dump_and_halt();
    endtask

    task automatic build_memory_program();
        clear_program();
        init_regs(16);
        repeat (12) emit(s_type(12'('h400 + 4 * ($urandom % 8)), 5'(1 + $urandom % 15)));
        repeat (12) begin
            emit(i_type(12'('h400 + 4 * ($urandom % 16)), 5'd0, 3'd2, 5'($urandom % 16), 7'h03));
        end
        emit(s_type(12'h480, 5'd5));
        emit(i_type(12'h480, 5'd0, 3'd2, 5'd6, 7'h03));
        repeat (4) begin
            emit({20'($urandom), 5'd21, 7'h37});
            emit(i_type(12'($urandom), 5'd21, 3'd0, 5'd21, 7'h13));
            emit(s_type(12'('h500 + 4 * ($urandom % 8)), 5'd21));
        end
        // writes to x0 must be dropped
        emit(i_type(12'd5, 5'd1, 3'd0, 5'd0, 7'h13));
        emit({20'($urandom), 5'd0, 7'h37});
        emit(i_type(12'h400, 5'd0, 3'd2, 5'd0, 7'h03));
        add_dump_and_halt();
    endtask

    task automatic run_test(input string name, input bit stall, input bit check_timing);
        int executed;
        int cycles;
        for (int i = 0; i < mem_words; i++) begin
            dmem[i] = fill_pattern(i);
            exp_mem[i] = dmem[i];
        end
        executed = run_reference();
        stall_enable = stall;
        reset_n = 1'b0;
        repeat (8) @(negedge clock);
        reset_n = 1'b1;
        cycles = 0;
        while (!halted && cycles < 50000) begin
            @(negedge clock);
            cycles++;
        end
        stall_enable = 1'b0;
        if (!halted) begin
            errors++;
            $display("%s: core did not halt before timeout", name);
        end
        // one init cycle plus 5N-1 cycles from the first fetch
        if (check_timing && cycles != 5 * executed) begin
            errors++;
            $display("[FAIL] %s halt cycle expected %0d actual %0d", name, 5 * executed, cycles);
        end
        repeat (50) begin
            @(negedge clock);
            if (!halted || data_ram_write) begin
                errors++;
                $display("%s: core left halt or wrote the data RAM after halting", name);
            end
        end
        for (int i = 0; i < mem_words; i++) begin
            if (dmem[i] !== exp_mem[i]) begin
                errors++;
                $display("[FAIL] %s addr %h expected %h actual %h", name, i * 4, exp_mem[i],
                         dmem[i]);
            end
        end
    endtask

    initial begin
        void'($urandom(74423));
        reset_n = 1'b0;
        run = 1'b1;
        stall_enable = 1'b0;
        inst_ram_read_data = '0;
        data_ram_read_data = '0;
        errors = 0;
        clear_program();
        init_regs(16);
        // the first ten cover every ALU kind once
        for (int k = 0; k < 40; k++) begin
            add_alu_op(16, (k < 10) ? k : $urandom % 10);
        end
        add_dump_and_halt();
        run_test("alu", 1'b0, 1'b0);
        run_test("run_freeze", 1'b1, 1'b0);
        build_control_program();
        run_test("control", 1'b0, 1'b0);
        build_memory_program();
        run_test("memory", 1'b0, 1'b0);
        clear_program();
        for (int k = 0; k < 20; k++) begin
            add_alu_op(16, (k < 10) ? k : $urandom % 10);
        end
        emit(i_type(12'd1, 5'd0, 3'd0, 5'd0, 7'h73));
        run_test("halt_timing", 1'b0, 1'b1);
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
